//--- hw/feeder_pkg.sv
`default_nettype none

package feeder_pkg;

    // ----------------------------------------------------------------------
    // widths and defaults
    // ----------------------------------------------------------------------
    localparam int XLEN = 32;
    localparam logic [XLEN-1:0] MMIO_BASE = 32'hC400_0000;

    // pipeline depth of the multiply-add unit
    localparam int MAC_LATENCY = 3;
    // entries in the pooling buffer
    localparam int POOL_DEPTH = 16;

    // ----------------------------------------------------------------------
    // register offsets from MMIO_BASE
    // ----------------------------------------------------------------------
    typedef enum logic [7:0] {
        DOT_A      = 8'h00,
        DOT_B      = 8'h04,
        DOT_RES    = 8'h08,
        ADD_A      = 8'h0C,
        ADD_B      = 8'h10,
        ADD_RES    = 8'h14,
        MUL_A      = 8'h18,
        MUL_B      = 8'h1C,
        MUL_RES    = 8'h20,
        POOL_SIZE  = 8'h24,
        POOL_DATA  = 8'h28,
        POOL_CNT   = 8'h2C,
        POOL_RES   = 8'h30,
        POOL_SCALE = 8'h34
    } mmio_reg_e;

    // tag carried through the pipe with each item
    typedef enum logic [1:0] {OP_DOT, OP_ADD, OP_MUL} mac_op_e;

    typedef enum logic [1:0] {POOL_IDLE, POOL_LOAD, POOL_SUM, POOL_SCALING} pool_state_e;

endpackage

`default_nettype wire

//--- hw/feeder_bus_if.sv
`default_nettype none

interface feeder_bus_if #(
    parameter int XLEN = feeder_pkg::XLEN
);
    import feeder_pkg::*;

    // decoded request, already qualified by the base address
    logic            wr;
    logic            rd;
    mmio_reg_e       reg_sel;
    logic [XLEN-1:0] wdata;

    // driven by the top-level decode
    modport source (
        output wr, rd, reg_sel, wdata
    );

    // each unit picks out its own offsets
    modport sink (
        input wr, rd, reg_sel, wdata
    );

endinterface

`default_nettype wire

//--- hw/mac_pipe.sv
`default_nettype none

module mac_pipe #(
    parameter int XLEN    = feeder_pkg::XLEN,
    parameter int LATENCY = feeder_pkg::MAC_LATENCY
) (
    input  logic                clk_i,
    input  logic                rst_i,
    input  logic                in_valid_i,
    input  feeder_pkg::mac_op_e in_op_i,
    input  logic [XLEN-1:0]     a_i,
    input  logic [XLEN-1:0]     b_i,
    input  logic [XLEN-1:0]     c_i,
    output logic                out_valid_o,
    output feeder_pkg::mac_op_e out_op_o,
    output logic [XLEN-1:0]     result_o
);
    import feeder_pkg::*;

    logic [LATENCY-1:0] valid_q;
    mac_op_e            op_q   [LATENCY];
    logic [XLEN-1:0]    data_q [LATENCY];
    logic [XLEN-1:0]    mac_sum;

    // keeps the low XLEN bits, so it wraps modulo 2^XLEN
    assign mac_sum = a_i * b_i + c_i;

    // valid bits walk down the stages
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            valid_q <= '0;
        end else begin
            valid_q[0] <= in_valid_i;
            for (int i = 1; i < LATENCY; i++) begin
                valid_q[i] <= valid_q[i-1];
            end
        end
    end

    // result and tag follow the same path
    always_ff @(posedge clk_i) begin
        op_q[0]   <= in_op_i;
        data_q[0] <= mac_sum;
        for (int i = 1; i < LATENCY; i++) begin
            op_q[i]   <= op_q[i-1];
            data_q[i] <= data_q[i-1];
        end
    end

    assign out_valid_o = valid_q[LATENCY-1];
    assign out_op_o    = op_q[LATENCY-1];
    assign result_o    = data_q[LATENCY-1];

endmodule

`default_nettype wire

//--- hw/arith_regs.sv
`default_nettype none

module arith_regs #(
    parameter int XLEN        = feeder_pkg::XLEN,
    parameter int MAC_LATENCY = feeder_pkg::MAC_LATENCY
) (
    input  logic            clk_i,
    input  logic            rst_i,
    feeder_bus_if.sink      bus,
    input  logic            dot_clear_i,
    output logic [XLEN-1:0] dot_res_o,
    output logic [XLEN-1:0] add_res_o,
    output logic [XLEN-1:0] mul_res_o
);
    import feeder_pkg::*;

    logic [XLEN-1:0] dot_a_q;
    logic [XLEN-1:0] add_a_q;
    logic [XLEN-1:0] mul_a_q;
    logic            b_write;
    logic            issue_valid_q;
    mac_op_e         issue_op_q;
    logic [XLEN-1:0] issue_a_q;
    logic [XLEN-1:0] issue_b_q;
    logic [XLEN-1:0] mac_b;
    logic [XLEN-1:0] mac_c;
    logic            res_valid;
    mac_op_e         res_op;
    logic [XLEN-1:0] res_data;

    // ----------------------------------------------------------------------
    // operand capture, a B write launches the op one cycle later
    // ----------------------------------------------------------------------
    assign b_write = bus.wr && (bus.reg_sel inside {DOT_B, ADD_B, MUL_B});

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            issue_valid_q <= 1'b0;
        end else begin
            issue_valid_q <= b_write;
        end
    end

    always_ff @(posedge clk_i) begin
        if (bus.wr) begin
            case (bus.reg_sel)
                DOT_A: dot_a_q <= bus.wdata;
                ADD_A: add_a_q <= bus.wdata;
                MUL_A: mul_a_q <= bus.wdata;
                DOT_B: begin
                    issue_op_q <= OP_DOT;
                    issue_a_q  <= dot_a_q;
                    issue_b_q  <= bus.wdata;
                end
                ADD_B: begin
                    issue_op_q <= OP_ADD;
                    issue_a_q  <= add_a_q;
                    issue_b_q  <= bus.wdata;
                end
                MUL_B: begin
                    issue_op_q <= OP_MUL;
                    issue_a_q  <= mul_a_q;
                    issue_b_q  <= bus.wdata;
                end
                default: ;
            endcase
        end
    end

    // add runs as A*1 + B, dot picks up the live accumulator
    always_comb begin
        mac_b = issue_b_q;
        mac_c = '0;
        case (issue_op_q)
            OP_DOT: mac_c = dot_res_o;
            OP_ADD: begin
                mac_b = {{(XLEN-1){1'b0}}, 1'b1};
                mac_c = issue_b_q;
            end
            default: ;
        endcase
    end

    mac_pipe #(
        .XLEN    (XLEN),
        .LATENCY (MAC_LATENCY)
    ) u_mac_pipe (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .in_valid_i  (issue_valid_q),
        .in_op_i     (issue_op_q),
        .a_i         (issue_a_q),
        .b_i         (mac_b),
        .c_i         (mac_c),
        .out_valid_o (res_valid),
        .out_op_o    (res_op),
        .result_o    (res_data)
    );

    // ----------------------------------------------------------------------
    // result registers, steered by the returning tag
    // ----------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            dot_res_o <= '0;
            add_res_o <= '0;
            mul_res_o <= '0;
        end else begin
            if (dot_clear_i) begin
                dot_res_o <= '0;
            end
            // a landing dot result overrides the clear
            if (res_valid && res_op == OP_DOT) begin
                dot_res_o <= res_data;
            end
            if (res_valid && res_op == OP_ADD) begin
                add_res_o <= res_data;
            end
            if (res_valid && res_op == OP_MUL) begin
                mul_res_o <= res_data;
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/pool_engine.sv
`default_nettype none

module pool_engine #(
    parameter int XLEN  = feeder_pkg::XLEN,
    parameter int DEPTH = feeder_pkg::POOL_DEPTH
) (
    input  logic            clk_i,
    input  logic            rst_i,
    feeder_bus_if.sink      bus,
    output logic [XLEN-1:0] pool_res_o,
    output logic            pool_busy_o
);
    import feeder_pkg::*;

    localparam int AW = $clog2(DEPTH);
    localparam int CW = $clog2(DEPTH + 1);

    pool_state_e     state_q;
    logic [XLEN-1:0] buf_mem [DEPTH];
    logic [CW-1:0]   count_q;
    logic [CW-1:0]   idx_q;
    logic [XLEN-1:0] scale_q;
    logic [XLEN-1:0] sum_q;
    logic            data_wr;

    // store the next entry while loading
    assign data_wr = (state_q == POOL_LOAD) && bus.wr && (bus.reg_sel == POOL_DATA)
                     && (idx_q != count_q);

    always_ff @(posedge clk_i) begin
        if (data_wr) begin
            buf_mem[idx_q[AW-1:0]] <= bus.wdata;
        end
    end

    // ----------------------------------------------------------------------
    // load / sum / scale FSM
    // ----------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q    <= POOL_IDLE;
            count_q    <= '0;
            idx_q      <= '0;
            scale_q    <= '0;
            pool_res_o <= '0;
        end else begin
            if (bus.wr && bus.reg_sel == POOL_SCALE) begin
                scale_q <= bus.wdata;
            end
            case (state_q)
                POOL_IDLE, POOL_LOAD: begin
                    if (bus.wr && bus.reg_sel == POOL_SIZE) begin
                        count_q <= bus.wdata[CW-1:0];
                        idx_q   <= '0;
                        state_q <= POOL_LOAD;
                    end else if (state_q == POOL_LOAD) begin
                        if (idx_q == count_q) begin
                            state_q <= POOL_IDLE;
                        end else if (data_wr) begin
                            idx_q <= idx_q + 1'b1;
                        end
                    end else if (bus.wr && bus.reg_sel == POOL_CNT) begin
                        idx_q   <= '0;
                        // empty buffer skips straight to the scale step
                        state_q <= (count_q == '0) ? POOL_SCALING : POOL_SUM;
                    end
                end
                POOL_SUM: begin
                    idx_q <= idx_q + 1'b1;
                    if (idx_q + 1'b1 == count_q) begin
                        state_q <= POOL_SCALING;
                    end
                end
                POOL_SCALING: begin
                    pool_res_o <= sum_q * scale_q;
                    state_q    <= POOL_IDLE;
                end
                default: state_q <= POOL_IDLE;
            endcase
        end
    end

    // running sum, one entry per cycle
    always_ff @(posedge clk_i) begin
        if (state_q != POOL_SUM) begin
            sum_q <= '0;
        end else begin
            sum_q <= sum_q + buf_mem[idx_q[AW-1:0]];
        end
    end

    assign pool_busy_o = (state_q == POOL_SUM) || (state_q == POOL_SCALING);

endmodule

`default_nettype wire

//--- hw/read_port.sv
`default_nettype none

module read_port #(
    parameter int XLEN = feeder_pkg::XLEN
) (
    input  logic            clk_i,
    input  logic            rst_i,
    feeder_bus_if.sink      bus,
    input  logic [XLEN-1:0] dot_res_i,
    input  logic [XLEN-1:0] add_res_i,
    input  logic [XLEN-1:0] mul_res_i,
    input  logic [XLEN-1:0] pool_res_i,
    input  logic            pool_busy_i,
    output logic [XLEN-1:0] data_o,
    output logic            dot_clear_o
);
    import feeder_pkg::*;

    logic rd_prev_q;
    logic first_rd;

    // a held read counts once
    assign first_rd = bus.rd && !rd_prev_q;

    // clears the accumulator on the same edge that latches it
    assign dot_clear_o = first_rd && (bus.reg_sel == DOT_RES);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            rd_prev_q <= 1'b0;
            data_o    <= '0;
        end else begin
            rd_prev_q <= bus.rd;
            if (bus.rd) begin
                case (bus.reg_sel)
                    // status, answered on every read cycle
                    POOL_CNT: data_o <= {{(XLEN-1){1'b0}}, pool_busy_i};
                    DOT_RES:  if (first_rd) data_o <= dot_res_i;
                    ADD_RES:  if (first_rd) data_o <= add_res_i;
                    MUL_RES:  if (first_rd) data_o <= mul_res_i;
                    POOL_RES: if (first_rd) data_o <= pool_res_i;
                    default: ;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/data_feeder.sv
`default_nettype none

module data_feeder #(
    parameter int XLEN        = feeder_pkg::XLEN,
    parameter int MAC_LATENCY = feeder_pkg::MAC_LATENCY,
    parameter int POOL_DEPTH  = feeder_pkg::POOL_DEPTH
) (
    input  logic            clk_i,
    input  logic            rst_i,
    input  logic            en_i,
    input  logic            we_i,
    input  logic [XLEN-1:0] addr_i,
    input  logic [XLEN-1:0] data_i,
    output logic [XLEN-1:0] data_o
);
    import feeder_pkg::*;

    logic            in_map;
    logic [XLEN-1:0] dot_res;
    logic [XLEN-1:0] add_res;
    logic [XLEN-1:0] mul_res;
    logic [XLEN-1:0] pool_res;
    logic            pool_busy;
    logic            dot_clear;

    feeder_bus_if #(.XLEN(XLEN)) bus ();

    // ----------------------------------------------------------------------
    // base address decode, word aligned offsets up to POOL_SCALE
    // ----------------------------------------------------------------------
    assign in_map = (addr_i[XLEN-1:8] == MMIO_BASE[XLEN-1:8]) && (addr_i[1:0] == 2'b00)
                    && (addr_i[7:0] <= POOL_SCALE);

    assign bus.wr      = en_i && we_i && in_map;
    assign bus.rd      = en_i && !we_i && in_map;
    assign bus.reg_sel = mmio_reg_e'(addr_i[7:0]);
    assign bus.wdata   = data_i;

    arith_regs #(
        .XLEN        (XLEN),
        .MAC_LATENCY (MAC_LATENCY)
    ) u_arith_regs (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .bus         (bus),
        .dot_clear_i (dot_clear),
        .dot_res_o   (dot_res),
        .add_res_o   (add_res),
        .mul_res_o   (mul_res)
    );

    pool_engine #(
        .XLEN  (XLEN),
        .DEPTH (POOL_DEPTH)
    ) u_pool_engine (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .bus         (bus),
        .pool_res_o  (pool_res),
        .pool_busy_o (pool_busy)
    );

    read_port #(
        .XLEN (XLEN)
    ) u_read_port (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .bus         (bus),
        .dot_res_i   (dot_res),
        .add_res_i   (add_res),
        .mul_res_i   (mul_res),
        .pool_res_i  (pool_res),
        .pool_busy_i (pool_busy),
        .data_o      (data_o),
        .dot_clear_o (dot_clear)
    );

endmodule

`default_nettype wire

//--- tb/tb_data_feeder.sv
`default_nettype none

module tb_data_feeder;
    import feeder_pkg::*;

    logic            clk;
    logic            rst;
    logic            en;
    logic            we;
    logic [XLEN-1:0] addr;
    logic [XLEN-1:0] wdata;
    logic [XLEN-1:0] rdata;

    int unsigned     error_count;
    int unsigned     timeout_count;
    // expected dot accumulator
    logic [XLEN-1:0] dot_model;

    data_feeder #(
        .XLEN        (XLEN),
        .MAC_LATENCY (MAC_LATENCY),
        .POOL_DEPTH  (POOL_DEPTH)
    ) u_data_feeder (
        .clk_i  (clk),
        .rst_i  (rst),
        .en_i   (en),
        .we_i   (we),
        .addr_i (addr),
        .data_i (wdata),
        .data_o (rdata)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ----------------------------------------------------------------------
    // bus access, all tasks start and end on a falling edge
    // ----------------------------------------------------------------------
    function automatic logic [XLEN-1:0] reg_addr(input mmio_reg_e off);
        return {MMIO_BASE[XLEN-1:8], off};
    endfunction

    task automatic idle_cycles(input int n);
        for (int i = 0; i < n; i++) begin
            @(negedge clk);
        end
    endtask

    task automatic bus_write(input mmio_reg_e off, input logic [XLEN-1:0] value);
        en    = 1'b1;
        we    = 1'b1;
        addr  = reg_addr(off);
        wdata = value;
        @(negedge clk);
        en = 1'b0;
        we = 1'b0;
    endtask

    // one idle cycle afterwards so the next read is a fresh one
    task automatic bus_read_held(input mmio_reg_e off, input int cycles,
                                 output logic [XLEN-1:0] value);
        en   = 1'b1;
        we   = 1'b0;
        addr = reg_addr(off);
        for (int i = 0; i < cycles; i++) begin
            @(negedge clk);
        end
        en    = 1'b0;
        value = rdata;
        @(negedge clk);
    endtask

    task automatic bus_read(input mmio_reg_e off, output logic [XLEN-1:0] value);
        bus_read_held(off, 1, value);
    endtask

    task automatic check_value(input string what, input logic [XLEN-1:0] got,
                               input logic [XLEN-1:0] exp);
        assert (got == exp) else begin
            error_count++;
            $display("** Error at %0t: %s read 0x%08h, expected 0x%08h",
                     $time, what, got, exp);
        end
    endtask

    // ----------------------------------------------------------------------
    // operations and model updates
    // ----------------------------------------------------------------------
    task automatic dot_step(input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
        bus_write(DOT_A, a);
        bus_write(DOT_B, b);
        idle_cycles(MAC_LATENCY + 2);
        dot_model = dot_model + a * b;
    endtask

    task automatic wait_pool_done();
        logic [XLEN-1:0] status;
        int              polls;
        polls  = 0;
        status = 1;
        while (status != 0 && polls < POOL_DEPTH + 8) begin
            bus_read(POOL_CNT, status);
            polls++;
        end
        if (status != 0) begin
            timeout_count++;
            $display("timeout: pooling engine still busy after %0d status reads", polls);
        end
    endtask

    task automatic run_pool();
        int              n;
        logic [XLEN-1:0] value;
        logic [XLEN-1:0] scale;
        logic [XLEN-1:0] sum;
        logic [XLEN-1:0] got;
        n   = $urandom_range(POOL_DEPTH, 1);
        sum = '0;
        bus_write(POOL_SIZE, n);
        for (int i = 0; i < n; i++) begin
            value = $urandom;
            bus_write(POOL_DATA, value);
            sum = sum + value;
        end
        scale = $urandom;
        bus_write(POOL_SCALE, scale);
        bus_write(POOL_CNT, '0);
        // engine must report busy straight away
        bus_read(POOL_CNT, got);
        check_value("POOL_CNT after start", got, 1);
        wait_pool_done();
        bus_read(POOL_RES, got);
        check_value("POOL_RES", got, sum * scale);
    endtask

    // ----------------------------------------------------------------------
    // main sequence
    // ----------------------------------------------------------------------
    initial begin
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] got;
        int unsigned     seed;
        en            = 1'b0;
        we            = 1'b0;
        addr          = '0;
        wdata         = '0;
        rst           = 1'b1;
        error_count   = 0;
        timeout_count = 0;
        dot_model     = '0;
        seed          = $urandom(939);

        idle_cycles(2);
        rst = 1'b0;
        idle_cycles(1);

        // results after reset
        bus_read(DOT_RES, got);
        check_value("DOT_RES after reset", got, '0);
        bus_read(ADD_RES, got);
        check_value("ADD_RES after reset", got, '0);
        bus_read(MUL_RES, got);
        check_value("MUL_RES after reset", got, '0);
        bus_read(POOL_RES, got);
        check_value("POOL_RES after reset", got, '0);

        // add and mul, both in flight together
        for (int r = 0; r < 8; r++) begin
            a = $urandom;
            b = $urandom;
            bus_write(ADD_A, a);
            bus_write(ADD_B, b);
            bus_write(MUL_A, a);
            bus_write(MUL_B, b);
            idle_cycles(MAC_LATENCY + 2);
            bus_read(ADD_RES, got);
            check_value("ADD_RES", got, a + b);
            bus_read(MUL_RES, got);
            check_value("MUL_RES", got, a * b);
        end

        // three dot steps, then read clears
        for (int r = 0; r < 3; r++) begin
            dot_step($urandom, $urandom);
        end
        bus_read(DOT_RES, got);
        check_value("DOT_RES after three steps", got, dot_model);
        dot_model = '0;
        bus_read(DOT_RES, got);
        check_value("DOT_RES after clear", got, '0);

        // a held read clears once only
        dot_step($urandom, $urandom);
        bus_read_held(DOT_RES, 3, got);
        check_value("DOT_RES held read", got, dot_model);
        dot_model = '0;
        dot_step($urandom, $urandom);
        bus_read(DOT_RES, got);
        check_value("DOT_RES after held read", got, dot_model);
        dot_model = '0;

        for (int r = 0; r < 4; r++) begin
            run_pool();
        end

        $display("errors: %0d, timeouts: %0d", error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- data_feeder.f
hw/feeder_pkg.sv
hw/feeder_bus_if.sv
hw/mac_pipe.sv
hw/arith_regs.sv
hw/pool_engine.sv
hw/read_port.sv
hw/data_feeder.sv
tb/tb_data_feeder.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing -f data_feeder.f --top-module tb_data_feeder -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -q "^TEST PASS$" sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed, see sim.log"
    exit 1
fi
